// File: src.f
+incdir+verification
common/plic_pkg.sv
common/axil_pkg.sv
axil_slave/plic_axil_slave.sv
design/plic_regs.sv
plic_core/plic_core.sv
design/plic_top.sv
verification/plic_tb.sv

// File: Bender.yml
package:
  name: plic

sources:
  - files:
      - common/plic_pkg.sv
      - common/axil_pkg.sv
      - axil_slave/plic_axil_slave.sv
      - design/plic_regs.sv
      - plic_core/plic_core.sv
      - design/plic_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/plic_tb.sv

// File: verification/plic_tb_tasks.svh
/*
 * Bus driver, compare and directed test tasks that plic_tb includes.
 * Inputs change 1 unit after the rising edge and outputs are read on the falling edge.
 */
`ifndef PLIC_TB_TASKS_SVH
`define PLIC_TB_TASKS_SVH

// handshake flag of the DUT selected by name
function automatic logic dut_flag(input string name);
    case (name)
        "awready": return axi_rsp.awready;
        "wready":  return axi_rsp.wready;
        "bvalid":  return axi_rsp.bvalid;
        "arready": return axi_rsp.arready;
        "rvalid":  return axi_rsp.rvalid;
        default:   return ext_irq;
    endcase
endfunction

// drive point just after the rising edge
task automatic after_edge();
    @(posedge clk);
    #1;
endtask

task automatic wait_high(input string name);
    int n;
    n = 0;
    @(negedge clk);
    while (!dut_flag(name) && n < TIMEOUT_CYCLES) begin
        @(negedge clk);
        n++;
    end
    if (!dut_flag(name)) begin
        $display("timeout while waiting for %s to go high", name);
        timeouts++;
    end
endtask

// ext_irq must stay low for the given number of cycles
task automatic hold_low(input int cycles);
    repeat (cycles) begin
        @(negedge clk);
        check_irq("ext_irq", ext_irq, 1'b0);
    end
endtask

task automatic set_sources(input irq_vec_t v);
    after_edge();
    irq_in = v;
endtask

task automatic check_data(input string name, input axil_data_t got, input axil_data_t exp);
    if (got !== exp) begin
        $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
        mismatches++;
    end
endtask

task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
    if (got !== exp) begin
        $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
        mismatches++;
    end
endtask

task automatic check_id(input string name, input irq_id_t got, input irq_id_t exp);
    if (got !== exp) begin
        $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
        mismatches++;
    end
endtask

task automatic check_irq(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
        mismatches++;
    end
endtask

// highest source that is both raised and enabled, or 0
function automatic irq_id_t expected_winner(input irq_vec_t raised, input irq_vec_t en);
    for (int i = NUM_IRQS; i >= 1; i--) begin
        if (raised[i-1] && en[i-1]) begin
            return irq_id_t'(i);
        end
    end
    return '0;
endfunction

// AW, then W, then B
task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                          output axil_resp_t resp);
    after_edge();
    axi_req.awvalid = 1'b1;
    axi_req.awaddr  = addr;
    wait_high("awready");
    after_edge();
    axi_req.awvalid = 1'b0;
    axi_req.wvalid  = 1'b1;
    axi_req.wdata   = data;
    wait_high("wready");
    after_edge();
    axi_req.wvalid = 1'b0;
    axi_req.bready = 1'b1;
    wait_high("bvalid");
    resp = axi_rsp.bresp;
    after_edge();
    axi_req.bready = 1'b0;
endtask

// stall is the number of cycles rready stays low once rvalid is up
task automatic axil_read(input axil_addr_t addr, input int stall,
                         output axil_data_t data, output axil_resp_t resp);
    after_edge();
    axi_req.arvalid = 1'b1;
    axi_req.araddr  = addr;
    wait_high("arready");
    after_edge();
    axi_req.arvalid = 1'b0;
    // address only has to be held until the AR transfer
    axi_req.araddr  = '0;
    wait_high("rvalid");
    data = axi_rsp.rdata;
    resp = axi_rsp.rresp;
    // response has to sit still under back-pressure
    repeat (stall) begin
        @(negedge clk);
        check_irq("rvalid", axi_rsp.rvalid, 1'b1);
        check_data("rdata", axi_rsp.rdata, data);
    end
    after_edge();
    axi_req.rready = 1'b1;
    after_edge();
    axi_req.rready = 1'b0;
endtask

task automatic test_reset_state();
    axil_data_t data;
    axil_resp_t resp;
    @(negedge clk);
    check_irq("ext_irq", ext_irq, 1'b0);
    check_irq("bvalid", axi_rsp.bvalid, 1'b0);
    check_irq("rvalid", axi_rsp.rvalid, 1'b0);
    axil_read(ADDR_ENABLE, 0, data, resp);
    check_data("enable", data, '0);
    check_resp("rresp", resp, RESP_OKAY);
endtask

task automatic test_enable_rw();
    axil_data_t wdata;
    axil_data_t data;
    axil_resp_t resp;
    wdata = $urandom;
    axil_write(ADDR_ENABLE, wdata, resp);
    check_resp("bresp", resp, RESP_OKAY);
    axil_read(ADDR_ENABLE, 0, data, resp);
    // only the low NUM_IRQS bits are kept
    check_data("enable", data, wdata & ((32'h1 << NUM_IRQS) - 1));
    check_resp("rresp", resp, RESP_OKAY);
endtask

task automatic test_claim(output irq_id_t id);
    irq_vec_t   raised;
    axil_data_t data;
    axil_resp_t resp;
    axil_write(ADDR_ENABLE, '1, resp);
    raised = irq_vec_t'($urandom);
    if (raised == '0) begin
        raised = irq_vec_t'(1);
    end
    set_sources(raised);
    wait_high("ext_irq");
    axil_read(ADDR_CLAIM, 0, data, resp);
    id = irq_id_t'(data);
    check_id("claim_id", id, expected_winner(raised, '1));
    check_resp("rresp", resp, RESP_OKAY);
    @(negedge clk);
    check_irq("ext_irq", ext_irq, 1'b0);
endtask

task automatic test_in_service(input irq_id_t id);
    irq_id_t    wrong;
    axil_data_t data;
    axil_resp_t resp;
    set_sources('1);
    hold_low(4);
    // any other valid id
    wrong = irq_id_t'((id % NUM_IRQS) + 1);
    axil_write(ADDR_CLAIM, axil_data_t'(wrong), resp);
    check_resp("bresp", resp, RESP_OKAY);
    hold_low(2);
    axil_write(ADDR_CLAIM, axil_data_t'(id), resp);
    @(negedge clk);
    check_irq("ext_irq", ext_irq, 1'b1);
    // every source is up now so the top one wins
    axil_read(ADDR_CLAIM, 0, data, resp);
    check_id("claim_id", irq_id_t'(data), irq_id_t'(NUM_IRQS));
    axil_write(ADDR_CLAIM, data, resp);
    set_sources('0);
endtask

task automatic test_disabled();
    irq_vec_t   en;
    axil_data_t data;
    axil_resp_t resp;
    axil_write(ADDR_ENABLE, '0, resp);
    set_sources('1);
    hold_low(4);
    axil_read(ADDR_CLAIM, 0, data, resp);
    check_id("claim_id", irq_id_t'(data), '0);
    // random subset with the top source left out
    en = irq_vec_t'($urandom) & ~(irq_vec_t'(1) << (NUM_IRQS - 1));
    if (en == '0) begin
        en = irq_vec_t'(1);
    end
    axil_write(ADDR_ENABLE, axil_data_t'(en), resp);
    wait_high("ext_irq");
    axil_read(ADDR_CLAIM, 0, data, resp);
    check_id("claim_id", irq_id_t'(data), expected_winner('1, en));
    axil_write(ADDR_CLAIM, data, resp);
    set_sources('0);
    axil_write(ADDR_ENABLE, '0, resp);
endtask

task automatic test_decode_error();
    axil_data_t data;
    axil_resp_t resp;
    axil_write(32'h0000_0010, 32'h1234_5678, resp);
    check_resp("bresp", resp, RESP_DECERR);
    axil_read(32'h0000_0010, 4, data, resp);
    check_data("rdata", data, 32'hFFFF_FFFF);
    check_resp("rresp", resp, RESP_DECERR);
endtask

`endif

// File: verification/plic_tb.sv
/*
 * Directed testbench for plic_top. Every wait is bounded by TIMEOUT_CYCLES.
 * Random masks come from $urandom with one fixed seed.
 */
module plic_tb;
    import axil_pkg::*;
    import plic_pkg::*;

    localparam int TIMEOUT_CYCLES = 100;
    localparam int unsigned SEED = 32'h1ae0_a060;

    logic      clk;
    logic      rst_n;
    irq_vec_t  irq_in;
    axil_req_t axi_req;
    axil_rsp_t axi_rsp;
    logic      ext_irq;

    // failure counters
    int mismatches;
    int timeouts;

    int unsigned seed;
    // id taken by the claim test, completed later
    irq_id_t claimed;

    `include "plic_tb_tasks.svh"

    plic_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .irq_in  (irq_in),
        .axi_req (axi_req),
        .axi_rsp (axi_rsp),
        .ext_irq (ext_irq)
    );

    // 10 unit period
    always #5 clk = ~clk;

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        irq_in     = '0;
        axi_req    = '0;
        mismatches = 0;
        timeouts   = 0;
        seed       = SEED;
        void'($urandom(seed));

        // 5 cycles in reset
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_enable_rw();
        test_claim(claimed);
        test_in_service(claimed);
        test_disabled();
        test_decode_error();

        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: design/plic_top.sv
/*
 * Controller top: AXI-lite bridge, register block and interrupt core.
 * Single clock domain. irq_in may be asynchronous, level-sensitive.
 */
module plic_top (
    input  logic                clk,
    input  logic                rst_n,
    input  plic_pkg::irq_vec_t  irq_in,
    input  axil_pkg::axil_req_t axi_req,
    output axil_pkg::axil_rsp_t axi_rsp,
    output logic                ext_irq
);
    import axil_pkg::*;
    import plic_pkg::*;

    // register bus between bridge and regs
    reg_req_t reg_req;
    reg_rsp_t reg_rsp;

    // regs to core
    irq_vec_t enable;
    logic     claim;
    logic     complete;
    irq_id_t  complete_id;
    irq_id_t  claim_id;

    plic_axil_slave i_axil_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .axi_req (axi_req),
        .axi_rsp (axi_rsp),
        .reg_req (reg_req),
        .reg_rsp (reg_rsp)
    );

    plic_regs i_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_req     (reg_req),
        .reg_rsp     (reg_rsp),
        .enable      (enable),
        .claim       (claim),
        .complete    (complete),
        .complete_id (complete_id),
        .claim_id    (claim_id)
    );

    plic_core i_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_in      (irq_in),
        .enable      (enable),
        .claim       (claim),
        .complete    (complete),
        .complete_id (complete_id),
        .claim_id    (claim_id),
        .ext_irq     (ext_irq)
    );

endmodule

// File: plic_core/plic_core.sv
/*
 * Interrupt core: two-flop synchronizers, enable masking and a fixed
 * highest-id-wins resolver. Level sources only, one target context.
 * ext_irq is held off from claim until the matching complete.
 */
module plic_core (
    input  logic               clk,
    input  logic               rst_n,
    input  plic_pkg::irq_vec_t irq_in,
    input  plic_pkg::irq_vec_t enable,
    input  logic               claim,
    input  logic               complete,
    input  plic_pkg::irq_id_t  complete_id,
    output plic_pkg::irq_id_t  claim_id,
    output logic               ext_irq
);
    import plic_pkg::*;

    // synchronizer stages
    irq_vec_t irq_meta;
    irq_vec_t irq_sync;
    irq_vec_t pending;

    // handler currently owns serviced_id
    logic     in_service;
    irq_id_t  serviced_id;

    // sources are asynchronous to clk
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_meta <= '0;
            irq_sync <= '0;
        end else begin
            irq_meta <= irq_in;
            irq_sync <= irq_meta;
        end
    end

    assign pending = irq_sync & enable;

    // ascending scan, the last hit is the highest pending source
    always_comb begin
        claim_id = '0;
        for (int i = 0; i < NUM_IRQS; i++) begin
            if (pending[i]) begin
                claim_id = irq_id_t'(i + 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_service <= 1'b0;
        end else if (claim) begin
            // an empty claim also drops a stale in-service state
            in_service <= (claim_id != '0);
        end else if (complete && in_service && (complete_id == serviced_id)) begin
            in_service <= 1'b0;
        end
    end

    // captured on every successful claim, later claims overwrite it
    always_ff @(posedge clk) begin
        if (claim && (claim_id != '0)) begin
            serviced_id <= claim_id;
        end
    end

    // notification to the core
    assign ext_irq = (|pending) && !in_service;

    a_serviced_id_valid: assert property (@(posedge clk) disable iff (!rst_n)
        in_service |-> (serviced_id != '0));

    // a successful claim silences the line from the next cycle on
    a_claim_masks_irq: assert property (@(posedge clk) disable iff (!rst_n)
        claim && (claim_id != '0) |=> in_service && !ext_irq);

endmodule

// File: design/plic_regs.sv
/*
 * Register block: enable mask at ADDR_ENABLE, claim/complete at ADDR_CLAIM.
 * Answers in the strobe cycle. Unmapped addresses flag err and read all ones.
 */
module plic_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  axil_pkg::reg_req_t reg_req,
    output axil_pkg::reg_rsp_t reg_rsp,
    output plic_pkg::irq_vec_t enable,
    output logic               claim,
    output logic               complete,
    output plic_pkg::irq_id_t  complete_id,
    input  plic_pkg::irq_id_t  claim_id
);
    import axil_pkg::*;
    import plic_pkg::*;

    logic hit_enable;
    logic hit_claim;

    assign hit_enable = (reg_req.addr == ADDR_ENABLE);
    assign hit_claim  = (reg_req.addr == ADDR_CLAIM);

    // id written back by the handler, upper bits ignored
    assign complete_id = reg_req.wdata[IRQ_ID_W-1:0];

    // claim on read, complete on write of the same register
    assign claim    = reg_req.rd && hit_claim;
    assign complete = reg_req.wr && hit_claim;

    // read mux and decode error
    always_comb begin
        reg_rsp.err   = 1'b0;
        reg_rsp.rdata = '0;
        if (hit_enable) begin
            // zero-extended mask
            reg_rsp.rdata = axil_data_t'(enable);
        end else if (hit_claim) begin
            reg_rsp.rdata = axil_data_t'(claim_id);
        end else begin
            // easy to spot in a debugger
            reg_rsp.err   = 1'b1;
            reg_rsp.rdata = '1;
        end
    end

    // enable mask, bit i gates source id i+1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable <= '0;
        end else if (reg_req.wr && hit_enable) begin
            enable <= reg_req.wdata[NUM_IRQS-1:0];
        end
    end

endmodule

// File: axil_slave/plic_axil_slave.sv
/*
 * AXI-lite slave that turns each transaction into one register-bus strobe.
 * One transaction in flight, write wins over read when both arrive in IDLE.
 * Responses are captured at the strobe and held until bready/rready.
 */
module plic_axil_slave (
    input  logic                clk,
    input  logic                rst_n,
    input  axil_pkg::axil_req_t axi_req,
    output axil_pkg::axil_rsp_t axi_rsp,
    output axil_pkg::reg_req_t  reg_req,
    input  axil_pkg::reg_rsp_t  reg_rsp
);
    import axil_pkg::*;

    axil_state_e state;
    axil_state_e state_next;

    // write address held between AW and W
    axil_addr_t  awaddr_q;

    // captured responses
    axil_data_t  rdata_q;
    axil_resp_t  rresp_q;
    axil_resp_t  bresp_q;

    logic        aw_hs;
    logic        w_hs;
    logic        ar_hs;

    // ready/valid come straight from the state
    always_comb begin
        axi_rsp.awready = (state == IDLE);
        // keep arready low while a write is offered so the read waits its turn
        axi_rsp.arready = (state == IDLE) && !axi_req.awvalid;
        axi_rsp.wready  = (state == WAIT_W);
        axi_rsp.bvalid  = (state == SEND_B);
        axi_rsp.bresp   = bresp_q;
        axi_rsp.rvalid  = (state == SEND_R);
        axi_rsp.rdata   = rdata_q;
        axi_rsp.rresp   = rresp_q;
    end

    assign aw_hs = axi_rsp.awready && axi_req.awvalid;
    assign w_hs  = axi_rsp.wready && axi_req.wvalid;
    assign ar_hs = axi_rsp.arready && axi_req.arvalid;

    // register-bus strobe in the W or AR transfer cycle
    always_comb begin
        reg_req.wr    = w_hs;
        reg_req.rd    = ar_hs;
        reg_req.addr  = w_hs ? awaddr_q : axi_req.araddr;
        reg_req.wdata = axi_req.wdata;
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (aw_hs) begin
                    state_next = WAIT_W;
                end else if (ar_hs) begin
                    state_next = SEND_R;
                end
            end
            WAIT_W: begin
                if (w_hs) begin
                    state_next = SEND_B;
                end
            end
            SEND_B: begin
                if (axi_req.bready) begin
                    state_next = IDLE;
                end
            end
            SEND_R: begin
                if (axi_req.rready) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // payload capture, only meaningful once the matching valid is up
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            awaddr_q <= axi_req.awaddr;
        end
        if (w_hs) begin
            bresp_q <= reg_rsp.err ? RESP_DECERR : RESP_OKAY;
        end
        // rdata sampled once so it stays put under back-pressure
        if (ar_hs) begin
            rdata_q <= reg_rsp.rdata;
            rresp_q <= reg_rsp.err ? RESP_DECERR : RESP_OKAY;
        end
    end

    // read data must not move while the master stalls
    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axi_rsp.rvalid && !axi_req.rready |=> axi_rsp.rvalid && $stable(axi_rsp.rdata));

    a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(reg_req.wr && reg_req.rd));

endmodule

// File: common/axil_pkg.sv
/*
 * AXI-lite channel bundles and the internal single-cycle register bus.
 * No wstrb or prot fields, so writes always cover the full 32-bit word.
 */
package axil_pkg;

    typedef logic [31:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_DECERR = 2'b11;

    // fields driven by the bus master
    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    // fields driven by the slave
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rsp_t;

    // one-cycle strobes, wr and rd are never high together
    typedef struct packed {
        logic       wr;
        logic       rd;
        axil_addr_t addr;
        axil_data_t wdata;
    } reg_req_t;

    // answered combinationally in the strobe cycle
    typedef struct packed {
        axil_data_t rdata;
        logic       err;
    } reg_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_W,
        SEND_B,
        SEND_R
    } axil_state_e;

endpackage

// File: common/plic_pkg.sv
/*
 * Interrupt controller constants: source count, id encoding and register map.
 * Sources are numbered 1..NUM_IRQS. Id 0 is reserved for "no interrupt".
 */
package plic_pkg;

    // number of level-sensitive interrupt sources
    localparam int NUM_IRQS = 5;

    // id width must hold 0 (none) up to NUM_IRQS
    localparam int IRQ_ID_W = $clog2(NUM_IRQS + 1);

    // one bit per source, bit i belongs to id i+1
    typedef logic [NUM_IRQS-1:0] irq_vec_t;

    // interrupt id, 0 means nothing pending
    typedef logic [IRQ_ID_W-1:0] irq_id_t;

    // register map, byte addresses on the register bus
    // enable mask, read/write
    localparam logic [31:0] ADDR_ENABLE = 32'h0000_0000;
    // claim on read, complete on write
    localparam logic [31:0] ADDR_CLAIM  = 32'h0000_0004;

endpackage
